/* logic/fetch_pkg.sv */
package fetch_pkg;

	////////////////////
	// pc source select
	////////////////////

	// width of the select field from the control unit
	localparam int pc_src_width = 2;

	// where the next pc comes from
	// anything other than pc_seq is a redirect and flushes if/id
	typedef enum logic [pc_src_width-1:0] {
		pc_seq    = 2'd0,
		pc_branch = 2'd1,
		pc_jump   = 2'd2,
		pc_reg    = 2'd3
	} pc_src_t;

	////////////////////
	// pc constants
	////////////////////

	// first fetch address after reset
	localparam int unsigned reset_pc = 0;

	// word addressed, so sequential fetch steps by one
	localparam int unsigned pc_step = 1;

endpackage

/* logic/isa_pkg.sv */
package isa_pkg;

	////////////////////
	// fixed encodings
	////////////////////

	// native instruction width of the isa
	// narrower builds keep the low bits
	localparam int isa_width = 32;

	// all zero word, decodes as sll r0,r0,0
	// used as the bubble on a flush
	localparam logic [isa_width-1:0] nop_word = '0;

	// all ones word ends the program
	// fetch only flags it, decode never sees it as an op
	localparam logic [isa_width-1:0] halt_word = '1;

endpackage

/* logic/imem_apb_if.sv */
`timescale 1ns/1ps

interface imem_apb_if #(
	parameter int data_width = 32
);

	// requester side
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [data_width-1:0] paddr;
	logic [data_width-1:0] pwdata;

	// completer side
	logic [data_width-1:0] prdata;
	logic                  pready;
	logic                  pslverr;

	// top level drives the bus
	modport master (
		output psel,
		output penable,
		output pwrite,
		output paddr,
		output pwdata,
		input  prdata,
		input  pready,
		input  pslverr
	);

	// instruction memory answers
	modport slave (
		input  psel,
		input  penable,
		input  pwrite,
		input  paddr,
		input  pwdata,
		output prdata,
		output pready,
		output pslverr
	);

endinterface

/* logic/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
	parameter int data_width = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  fetch_pkg::pc_src_t    pc_src,
	input  logic [data_width-1:0] branch_addr,
	input  logic [data_width-1:0] jump_addr,
	input  logic [data_width-1:0] reg_addr,
	output logic [data_width-1:0] pc,
	output logic [data_width-1:0] pc_plus_one
);

	logic [data_width-1:0] next_pc;
	logic                  redirect;

	////////////////////
	// incrementer
	////////////////////

	// wraps at the top of the address space
	assign pc_plus_one = pc + data_width'(fetch_pkg::pc_step);

	// any non sequential source
	assign redirect = (pc_src != fetch_pkg::pc_seq);

	////////////////////
	// next pc mux
	////////////////////

	always_comb begin
		// default keeps the sequential path
		next_pc = pc_plus_one;
		unique case (pc_src)
			fetch_pkg::pc_seq: begin
				next_pc = pc_plus_one;
			end
			fetch_pkg::pc_branch: begin
				next_pc = branch_addr;
			end
			fetch_pkg::pc_jump: begin
				next_pc = jump_addr;
			end
			fetch_pkg::pc_reg: begin
				// jr / jalr target from the register file
				next_pc = reg_addr;
			end
		endcase
	end

	////////////////////
	// pc register
	////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= data_width'(fetch_pkg::reset_pc);
		end else if (redirect || !stall) begin
			// redirect wins over stall
			pc <= next_pc;
		end
	end

	// select must be driven once out of reset
	// an x here would silently pick a branch target
	a_pc_src_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(pc_src)
	);

endmodule

/* logic/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem #(
	parameter int data_width = 32,
	parameter int imem_depth = 256
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [data_width-1:0] pc,
	output logic [data_width-1:0] fetch_word,
	imem_apb_if.slave             apb
);

	// index bits for the word array
	localparam int idx_width = (imem_depth > 1) ? $clog2(imem_depth) : 1;

	logic [data_width-1:0] mem [imem_depth];

	logic                  pc_in_range;
	logic                  apb_setup;
	logic                  apb_access;
	logic                  addr_ok;
	logic [idx_width-1:0]  apb_idx;
	logic [data_width-1:0] rd_data_q;
	logic                  err_q;

	////////////////////
	// fetch read port
	////////////////////

	// no clock on this path, word follows pc in the same cycle
	assign pc_in_range = (pc < data_width'(imem_depth));

	// off the end of the program reads as a bubble
	assign fetch_word = pc_in_range ? mem[pc[idx_width-1:0]]
	                                : data_width'(isa_pkg::nop_word);

	////////////////////
	// apb decode
	////////////////////

	assign apb_setup  = apb.psel && !apb.penable;
	assign apb_access = apb.psel && apb.penable;
	assign addr_ok    = (apb.paddr < data_width'(imem_depth));
	assign apb_idx    = apb.paddr[idx_width-1:0];

	// zero wait states
	assign apb.pready = 1'b1;

	// write lands on the edge that ends the access phase
	// out of range writes are dropped
	always_ff @(posedge clk) begin
		if (apb_access && apb.pwrite && addr_ok) begin
			mem[apb_idx] <= apb.pwdata;
		end
	end

	// readback word sampled at the end of setup
	// so it is stable for the whole access phase
	always_ff @(posedge clk) begin
		if (apb_setup && addr_ok) begin
			rd_data_q <= mem[apb_idx];
		end
	end

	// range error also decided in setup
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			err_q <= 1'b0;
		end else begin
			err_q <= apb_setup && !addr_ok;
		end
	end

	// only meaningful while the access phase is up
	assign apb.prdata  = (apb_access && !apb.pwrite) ? rd_data_q : '0;
	assign apb.pslverr = apb_access && err_q;

	// protocol checks on the requester
	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (reset)
		apb.penable |-> apb.psel
	);

	// setup must go straight to access with the same address
	a_paddr_stable: assert property (
		@(posedge clk) disable iff (reset)
		apb_setup |=> (apb_access && $stable(apb.paddr))
	);

endmodule

/* logic/if_id_latch.sv */
`timescale 1ns/1ps

module if_id_latch #(
	parameter int data_width = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  fetch_pkg::pc_src_t    pc_src,
	input  logic [data_width-1:0] pc,
	input  logic [data_width-1:0] pc_plus_one,
	input  logic [data_width-1:0] fetch_word,
	output logic [data_width-1:0] id_instr,
	output logic [data_width-1:0] id_pc,
	output logic [data_width-1:0] id_pc_plus_one,
	output logic                  halted
);

	logic flush;
	logic capture;
	logic is_halt;

	// wrong path word gets squashed on any redirect
	assign flush   = (pc_src != fetch_pkg::pc_seq);
	assign capture = !flush && !stall;

	// compare against the native encoding cut to width
	assign is_halt = (fetch_word == data_width'(isa_pkg::halt_word));

	////////////////////
	// if/id register
	////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			id_instr       <= '0;
			id_pc          <= '0;
			id_pc_plus_one <= '0;
		end else if (flush) begin
			// bubble, pc fields zeroed too
			id_instr       <= data_width'(isa_pkg::nop_word);
			id_pc          <= '0;
			id_pc_plus_one <= '0;
		end else if (capture) begin
			id_instr       <= fetch_word;
			id_pc          <= pc;
			id_pc_plus_one <= pc_plus_one;
		end
	end

	// sticky halt for the debug unit
	// set only when the halt word is actually latched
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			halted <= 1'b0;
		end else if (capture && is_halt) begin
			halted <= 1'b1;
		end
	end

	a_halt_sticky: assert property (
		@(posedge clk) disable iff (reset)
		!$fell(halted)
	);

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
	parameter int data_width = 32,
	parameter int imem_depth = 256
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  fetch_pkg::pc_src_t    pc_src,
	input  logic [data_width-1:0] branch_addr,
	input  logic [data_width-1:0] jump_addr,
	input  logic [data_width-1:0] reg_addr,
	// program load port
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [data_width-1:0] paddr,
	input  logic [data_width-1:0] pwdata,
	output logic [data_width-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	// to decode
	output logic [data_width-1:0] pc,
	output logic [data_width-1:0] id_instr,
	output logic [data_width-1:0] id_pc,
	output logic [data_width-1:0] id_pc_plus_one,
	output logic                  halted
);

	logic [data_width-1:0] pc_plus_one;
	logic [data_width-1:0] fetch_word;

	////////////////////
	// apb bundle
	////////////////////

	imem_apb_if #(.data_width(data_width)) apb_i ();

	assign apb_i.psel    = psel;
	assign apb_i.penable = penable;
	assign apb_i.pwrite  = pwrite;
	assign apb_i.paddr   = paddr;
	assign apb_i.pwdata  = pwdata;
	assign prdata        = apb_i.prdata;
	assign pready        = apb_i.pready;
	assign pslverr       = apb_i.pslverr;

	////////////////////
	// fetch datapath
	////////////////////

	pc_unit #(.data_width(data_width)) pc_unit_i (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.pc_src      (pc_src),
		.branch_addr (branch_addr),
		.jump_addr   (jump_addr),
		.reg_addr    (reg_addr),
		.pc          (pc),
		.pc_plus_one (pc_plus_one)
	);

	instr_mem #(
		.data_width (data_width),
		.imem_depth (imem_depth)
	) instr_mem_i (
		.clk        (clk),
		.reset      (reset),
		.pc         (pc),
		.fetch_word (fetch_word),
		.apb        (apb_i.slave)
	);

	if_id_latch #(.data_width(data_width)) if_id_latch_i (
		.clk            (clk),
		.reset          (reset),
		.stall          (stall),
		.pc_src         (pc_src),
		.pc             (pc),
		.pc_plus_one    (pc_plus_one),
		.fetch_word     (fetch_word),
		.id_instr       (id_instr),
		.id_pc          (id_pc),
		.id_pc_plus_one (id_pc_plus_one),
		.halted         (halted)
	);

endmodule

/* verif/fetch_stage_tb.sv */
`timescale 1ns/1ps

module fetch_stage_tb;

	localparam int data_width   = 32;
	localparam int imem_depth   = 256;
	localparam int idx_width    = $clog2(imem_depth);
	localparam int reset_cycles = 4;
	localparam int load_words   = 32;
	localparam int settle_ns    = 10;
	// two cycles per apb transfer, load and readback plus the range probes
	localparam int apb_cycles   = 2 * (2 * load_words + 4);
	// sequential, stall, redirect and halt sections
	localparam int fetch_cycles = 60;
	localparam int cycle_limit  = 2 * (reset_cycles + apb_cycles + fetch_cycles);

	typedef logic [data_width-1:0] word_t;

	logic               clk;
	logic               reset;
	logic               stall;
	fetch_pkg::pc_src_t pc_src;
	word_t              branch_addr;
	word_t              jump_addr;
	word_t              reg_addr;
	logic               psel;
	logic               penable;
	logic               pwrite;
	word_t              paddr;
	word_t              pwdata;
	word_t              prdata;
	logic               pready;
	logic               pslverr;
	word_t              pc;
	word_t              id_instr;
	word_t              id_pc;
	word_t              id_pc_plus_one;
	logic               halted;

	// mirror of the program in the dut
	word_t       golden_mem [imem_depth];
	logic [31:0] lcg_state;
	int          cycle_count;

	fetch_stage #(
		.data_width (data_width),
		.imem_depth (imem_depth)
	) dut_i (.*);

	always #50 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: tests still running after %0d clock cycles", cycle_limit);
			stop_run();
		end
	end

	////////////////////
	// helpers
	////////////////////

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "fetch stage testbench stopped");
	endtask

	task automatic expect_word(input string what, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic word_t gold_word(input word_t addr);
		return golden_mem[addr[idx_width-1:0]];
	endfunction

	// called at a falling edge, returns at the falling edge after the access
	task automatic apb_transfer(input logic write, input word_t addr, input word_t data,
			output word_t rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		// access phase, let the combinational outputs settle
		#settle_ns;
		expect_word("pready", word_t'(pready), word_t'(1'b1));
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic reset_and_load();
		word_t addr;
		word_t w;
		word_t rdata;
		logic  err;
		expect_word("pc after reset", pc, word_t'(fetch_pkg::reset_pc));
		expect_word("id_instr after reset", id_instr, '0);
		expect_word("id_pc after reset", id_pc, '0);
		expect_word("id_pc_plus_one after reset", id_pc_plus_one, '0);
		expect_word("halted after reset", word_t'(halted), '0);
		expect_word("pslverr after reset", word_t'(pslverr), '0);
		// fetch held at address 0 while loading
		for (addr = '0; addr < load_words; addr++) begin
			do begin
				lcg_state = lcg_next(lcg_state);
				w         = word_t'(lcg_state);
			end while (w == word_t'(isa_pkg::halt_word));
			golden_mem[addr[idx_width-1:0]] = w;
			apb_transfer(1'b1, addr, w, rdata, err);
			expect_word("pslverr on load", word_t'(err), '0);
		end
		for (addr = '0; addr < load_words; addr++) begin
			apb_transfer(1'b0, addr, '0, rdata, err);
			expect_word("readback word", rdata, gold_word(addr));
			expect_word("pslverr on readback", word_t'(err), '0);
		end
		// one past the end, aliases index 0 if the write were kept
		apb_transfer(1'b1, word_t'(imem_depth), ~gold_word('0), rdata, err);
		expect_word("pslverr on range write", word_t'(err), word_t'(1'b1));
		apb_transfer(1'b0, word_t'(imem_depth), '0, rdata, err);
		expect_word("pslverr on range read", word_t'(err), word_t'(1'b1));
		apb_transfer(1'b0, '0, '0, rdata, err);
		expect_word("word 0 after dropped write", rdata, gold_word('0));
		expect_word("halted after load", word_t'(halted), '0);
	endtask

	task automatic sequential_fetch(input int cycles);
		word_t pc_prev;
		stall  = 1'b0;
		pc_src = fetch_pkg::pc_seq;
		repeat (cycles) begin
			pc_prev = pc;
			@(negedge clk);
			expect_word("id_instr", id_instr, gold_word(pc_prev));
			expect_word("id_pc", id_pc, pc_prev);
			expect_word("id_pc_plus_one", id_pc_plus_one, pc_prev + 1'b1);
			expect_word("pc", pc, pc_prev + 1'b1);
		end
	endtask

	task automatic stall_hold(input int cycles);
		word_t held_pc;
		word_t held_instr;
		word_t held_id_pc;
		word_t held_plus_one;
		held_pc       = pc;
		held_instr    = id_instr;
		held_id_pc    = id_pc;
		held_plus_one = id_pc_plus_one;
		stall         = 1'b1;
		pc_src        = fetch_pkg::pc_seq;
		repeat (cycles) begin
			@(negedge clk);
			expect_word("pc in stall", pc, held_pc);
			expect_word("id_instr in stall", id_instr, held_instr);
			expect_word("id_pc in stall", id_pc, held_id_pc);
			expect_word("id_pc_plus_one in stall", id_pc_plus_one, held_plus_one);
		end
		// resumes at the held address
		stall = 1'b0;
		@(negedge clk);
		expect_word("id_instr after stall", id_instr, gold_word(held_pc));
		expect_word("id_pc after stall", id_pc, held_pc);
		expect_word("pc after stall", pc, held_pc + 1'b1);
	endtask

	task automatic redirect_check(input fetch_pkg::pc_src_t src, input logic with_stall,
			input word_t b_addr, input word_t j_addr, input word_t r_addr);
		word_t target;
		case (src)
			fetch_pkg::pc_branch: target = b_addr;
			fetch_pkg::pc_jump:   target = j_addr;
			default:              target = r_addr;
		endcase
		branch_addr = b_addr;
		jump_addr   = j_addr;
		reg_addr    = r_addr;
		pc_src      = src;
		stall       = with_stall;
		@(negedge clk);
		expect_word("pc after redirect", pc, target);
		expect_word("bubble id_instr", id_instr, word_t'(isa_pkg::nop_word));
		expect_word("bubble id_pc", id_pc, '0);
		expect_word("bubble id_pc_plus_one", id_pc_plus_one, '0);
		pc_src = fetch_pkg::pc_seq;
		stall  = 1'b0;
		@(negedge clk);
		expect_word("id_instr at target", id_instr, gold_word(target));
		expect_word("id_pc at target", id_pc, target);
		expect_word("pc past target", pc, target + 1'b1);
	endtask

	task automatic halt_check();
		word_t halt_addr;
		word_t rdata;
		logic  err;
		halt_addr = word_t'(load_words - 1);
		stall     = 1'b1;
		apb_transfer(1'b1, halt_addr, word_t'(isa_pkg::halt_word), rdata, err);
		expect_word("pslverr on halt write", word_t'(err), '0);
		golden_mem[halt_addr[idx_width-1:0]] = word_t'(isa_pkg::halt_word);
		// land two words short of the halt
		jump_addr = halt_addr - 2'd2;
		pc_src    = fetch_pkg::pc_jump;
		stall     = 1'b0;
		@(negedge clk);
		pc_src = fetch_pkg::pc_seq;
		repeat (2) begin
			@(negedge clk);
			expect_word("halted before halt word", word_t'(halted), '0);
		end
		@(negedge clk);
		expect_word("id_instr at halt", id_instr, word_t'(isa_pkg::halt_word));
		expect_word("halted on halt word", word_t'(halted), word_t'(1'b1));
		repeat (4) begin
			@(negedge clk);
			expect_word("halted after halt word", word_t'(halted), word_t'(1'b1));
		end
		// only reset clears it
		reset = 1'b1;
		@(negedge clk);
		expect_word("halted in reset", word_t'(halted), '0);
		expect_word("pc in reset", pc, word_t'(fetch_pkg::reset_pc));
		reset = 1'b0;
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		stall       = 1'b1;
		pc_src      = fetch_pkg::pc_seq;
		branch_addr = '0;
		jump_addr   = '0;
		reg_addr    = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		lcg_state   = 32'hea94;
		cycle_count = 0;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;

		reset_and_load();
		sequential_fetch(10);
		stall_hold(4);
		// each call picks one of three distinct targets
		redirect_check(fetch_pkg::pc_branch, 1'b0, 5, 12, 19);
		redirect_check(fetch_pkg::pc_jump, 1'b0, 6, 13, 20);
		redirect_check(fetch_pkg::pc_reg, 1'b0, 3, 17, 9);
		redirect_check(fetch_pkg::pc_branch, 1'b1, 22, 2, 8);
		redirect_check(fetch_pkg::pc_jump, 1'b1, 10, 23, 4);
		redirect_check(fetch_pkg::pc_reg, 1'b1, 15, 11, 24);
		halt_check();

		// any failed check has already stopped the run
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* compile.f */
logic/fetch_pkg.sv
logic/isa_pkg.sv
logic/imem_apb_if.sv
logic/pc_unit.sv
logic/instr_mem.sv
logic/if_id_latch.sv
logic/fetch_stage.sv
verif/fetch_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fetch stage testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module fetch_stage_tb -o fetch_stage_sim > build.log 2>&1 \
	&& ./obj_dir/fetch_stage_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error, see build.log and sim.log"

grep -qF "*** TEST PASSED ***" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
